/* verilog.f */
src/devTlbCfgPkg.sv
src/devTlbTypesPkg.sv
src/missTrkIf.sv
src/missIntake.sv
src/missTrkEntry.sv
src/missOutArb.sv
src/devTlbMissTop.sv
bench/devTlbMissTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the miss tracker testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module devTlbMissTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0

/* bench/devTlbMissTb.sv */
// ----------------------------------------------------------------------
// requester, translation agent and page request agent around the top
// agents serve one request at a time; delays from a 17-bit LFSR
// ----------------------------------------------------------------------

module devTlbMissTb;

    localparam int NumRows = 10;
    localparam int CycleLimit = NumRows * 400;
    // offset the agent adds once an invalidation has passed
    localparam devTlbTypesPkg::physPage_t InvShift = 24'h400000;
    localparam int WinLen = 12;

    typedef struct {
        devTlbTypesPkg::virtPage_t virt;
        logic wrOp;
        int nErr;
        int nNp;
        logic prsOk;
        logic doInv;
        logic afterInv;
        logic waitFill;
        devTlbTypesPkg::physPage_t off;
        devTlbTypesPkg::physPage_t expPhys;
        logic expFault;
        int expAts;
        int expPrs;
    } missRow_t;

    logic clk;
    logic rstN;
    logic missReq;
    devTlbTypesPkg::virtPage_t missAddr;
    logic missWrOp;
    logic missAck;
    logic invStart;
    logic invEnd;
    logic atsReq;
    logic atsAck;
    devTlbTypesPkg::trkTag_t atsTag;
    devTlbTypesPkg::virtPage_t atsAddr;
    logic atsRsp;
    devTlbTypesPkg::trkTag_t atsRspTag;
    devTlbTypesPkg::atsSts_t atsRspSts;
    devTlbTypesPkg::physPage_t atsRspPhys;
    logic prsReq;
    logic prsAck;
    devTlbTypesPkg::trkTag_t prsTag;
    devTlbTypesPkg::virtPage_t prsAddr;
    logic prsRsp;
    devTlbTypesPkg::trkTag_t prsRspTag;
    devTlbTypesPkg::prsSts_t prsRspSts;
    logic fillVld;
    devTlbTypesPkg::virtPage_t fillAddr;
    devTlbTypesPkg::physPage_t fillPhys;
    logic fillFault;
    logic fillWrOp;

    missRow_t rows [NumRows];
    int errLeft [NumRows];
    int npLeft [NumRows];
    int atsCount [NumRows];
    int prsCount [NumRows];
    logic invDone [NumRows];
    logic fillSeen [NumRows];
    // page of the last not-present answer per tag
    devTlbTypesPkg::virtPage_t npPage [devTlbCfgPkg::NumTrk];
    logic invWin;
    logic ackPrev;
    int ackCount;
    int fillCount;
    int valErrs;
    int protoErrs;
    int cycles;
    logic [16:0] atsLfsr = 17'd94011;
    logic [16:0] prsLfsr = 17'd94011;

    devTlbMissTop devTlbMissTop_inst (.clk(clk), .rstN(rstN), .missReq(missReq),
        .missAddr(missAddr), .missWrOp(missWrOp), .missAck(missAck), .invStart(invStart),
        .invEnd(invEnd), .atsReq(atsReq), .atsAck(atsAck), .atsTag(atsTag), .atsAddr(atsAddr),
        .atsRsp(atsRsp), .atsRspTag(atsRspTag), .atsRspSts(atsRspSts),
        .atsRspPhys(atsRspPhys), .prsReq(prsReq), .prsAck(prsAck), .prsTag(prsTag),
        .prsAddr(prsAddr), .prsRsp(prsRsp), .prsRspTag(prsRspTag), .prsRspSts(prsRspSts),
        .fillVld(fillVld), .fillAddr(fillAddr), .fillPhys(fillPhys), .fillFault(fillFault),
        .fillWrOp(fillWrOp));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    // fibonacci, taps 17 and 14
    function automatic logic [16:0] stepLfsr(input logic [16:0] st);
        return {st[15:0], st[16] ^ st[13]};
    endfunction

    task automatic drawDelay(inout logic [16:0] st, input int nBits, output int dly);
        int i;
        dly = 0;
        for (i = 0; i < nBits; i++) begin
            st = stepLfsr(st);
            dly = (dly << 1) | int'(st[0]);
        end
    endtask

    function automatic int findRow(input devTlbTypesPkg::virtPage_t page);
        int i;
        for (i = 0; i < NumRows; i++) begin
            if (rows[i].virt == page) return i;
        end
        return -1;
    endfunction

    task automatic addRow(input int i, input devTlbTypesPkg::virtPage_t virt, input logic wrOp,
                          input int nErr, input int nNp, input logic prsOk, input logic doInv,
                          input logic afterInv, input logic waitFill,
                          input devTlbTypesPkg::physPage_t off,
                          input devTlbTypesPkg::physPage_t expPhys, input logic expFault,
                          input int expAts, input int expPrs);
        rows[i].virt = virt;
        rows[i].wrOp = wrOp;
        rows[i].nErr = nErr;
        rows[i].nNp = nNp;
        rows[i].prsOk = prsOk;
        rows[i].doInv = doInv;
        rows[i].afterInv = afterInv;
        rows[i].waitFill = waitFill;
        rows[i].off = off;
        rows[i].expPhys = expPhys;
        rows[i].expFault = expFault;
        rows[i].expAts = expAts;
        rows[i].expPrs = expPrs;
    endtask

    task automatic checkPhys(input devTlbTypesPkg::physPage_t got,
                             input devTlbTypesPkg::physPage_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            valErrs++;
        end
    endtask

    task automatic checkAddr(input devTlbTypesPkg::virtPage_t got,
                             input devTlbTypesPkg::virtPage_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            valErrs++;
        end
    endtask

    task automatic checkFault(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
            valErrs++;
        end
    endtask

    task automatic checkWrOp(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
            valErrs++;
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            valErrs++;
        end
    endtask

    // ------------------------------------------------------------------
    // requester side
    // ------------------------------------------------------------------
    task automatic presentMiss(input int r);
        // this row must arrive inside the invalidation window
        if (rows[r].afterInv) begin
            while (!invWin) @(posedge clk);
        end
        missReq <= 1'b1;
        missAddr <= rows[r].virt;
        missWrOp <= rows[r].wrOp;
        do @(posedge clk); while (!missAck);
        missReq <= 1'b0;
        do @(posedge clk); while (missAck);
        if (rows[r].waitFill) begin
            do @(posedge clk); while (!(fillVld && fillAddr == rows[r].virt));
        end
    endtask

    // ------------------------------------------------------------------
    // translation agent, one outstanding request
    // ------------------------------------------------------------------
    task automatic serveAts();
        int r;
        int dly;
        int i;
        devTlbTypesPkg::trkTag_t tag;
        devTlbTypesPkg::virtPage_t addr;
        devTlbTypesPkg::atsSts_t sts;
        devTlbTypesPkg::physPage_t phys;
        logic stale;
        tag = atsTag;
        addr = atsAddr;
        r = findRow(addr);
        atsAck <= 1'b1;
        do @(posedge clk); while (atsReq);
        atsAck <= 1'b0;
        if (r < 0) begin
            $display("Error at %0t: translation request for unknown page %h", $time, addr);
            protoErrs++;
            return;
        end
        atsCount[r]++;
        drawDelay(atsLfsr, 3, dly);
        stale = rows[r].doInv && !invDone[r];
        if (stale) begin
            // open the window while this request is outstanding
            invStart <= 1'b1;
            invWin <= 1'b1;
            @(posedge clk);
            invStart <= 1'b0;
        end
        repeat (dly + 1) @(posedge clk);
        phys = devTlbTypesPkg::physPage_t'(addr) + rows[r].off;
        if (invDone[r]) phys = phys + InvShift;
        if (stale) begin
            sts = devTlbTypesPkg::atsOk;
            invDone[r] = 1'b1;
        end else if (errLeft[r] > 0) begin
            sts = devTlbTypesPkg::atsErr;
            errLeft[r]--;
        end else if (npLeft[r] > 0) begin
            sts = devTlbTypesPkg::atsNotPresent;
            npLeft[r]--;
            npPage[tag] = addr;
        end else begin
            sts = devTlbTypesPkg::atsOk;
        end
        atsRsp <= 1'b1;
        atsRspTag <= tag;
        atsRspSts <= sts;
        atsRspPhys <= phys;
        @(posedge clk);
        atsRsp <= 1'b0;
        if (stale) begin
            // nothing may be requested until the window closes
            for (i = 0; i < WinLen; i++) begin
                @(posedge clk);
                if (atsReq) begin
                    $display("Error at %0t: translation request inside the window", $time);
                    protoErrs++;
                end
            end
            invEnd <= 1'b1;
            invWin <= 1'b0;
            @(posedge clk);
            invEnd <= 1'b0;
        end
    endtask

    initial begin
        atsAck = 1'b0;
        atsRsp = 1'b0;
        atsRspTag = '0;
        atsRspSts = devTlbTypesPkg::atsOk;
        atsRspPhys = '0;
        invStart = 1'b0;
        invEnd = 1'b0;
        invWin = 1'b0;
        @(posedge rstN);
        for (int r = 0; r < NumRows; r++) begin
            errLeft[r] = rows[r].nErr;
            npLeft[r] = rows[r].nNp;
            atsCount[r] = 0;
            invDone[r] = 1'b0;
        end
        forever begin
            @(posedge clk);
            if (atsReq === 1'b1 && atsAck == 1'b0) serveAts();
        end
    end

    // ------------------------------------------------------------------
    // page request agent
    // ------------------------------------------------------------------
    task automatic servePrs();
        int r;
        int dly;
        devTlbTypesPkg::trkTag_t tag;
        devTlbTypesPkg::virtPage_t addr;
        tag = prsTag;
        addr = prsAddr;
        r = findRow(addr);
        checkAddr(addr, npPage[tag], "page request address");
        prsAck <= 1'b1;
        do @(posedge clk); while (prsReq);
        prsAck <= 1'b0;
        if (r < 0) begin
            $display("Error at %0t: page request for unknown page %h", $time, addr);
            protoErrs++;
            return;
        end
        prsCount[r]++;
        drawDelay(prsLfsr, 3, dly);
        repeat (dly + 1) @(posedge clk);
        prsRsp <= 1'b1;
        prsRspTag <= tag;
        if (rows[r].prsOk) prsRspSts <= devTlbTypesPkg::prsSuccess;
        else prsRspSts <= devTlbTypesPkg::prsFailure;
        @(posedge clk);
        prsRsp <= 1'b0;
    endtask

    initial begin
        prsAck = 1'b0;
        prsRsp = 1'b0;
        prsRspTag = '0;
        prsRspSts = devTlbTypesPkg::prsSuccess;
        @(posedge rstN);
        for (int r = 0; r < NumRows; r++) prsCount[r] = 0;
        forever begin
            @(posedge clk);
            if (prsReq === 1'b1 && prsAck == 1'b0) servePrs();
        end
    end

    // ------------------------------------------------------------------
    // fill and ack monitor
    // ------------------------------------------------------------------
    task automatic watchOutputs();
        int r;
        if (fillVld) begin
            r = findRow(fillAddr);
            if (r < 0) begin
                $display("Error at %0t: fill for page %h never requested", $time, fillAddr);
                protoErrs++;
            end else if (fillSeen[r]) begin
                $display("Error at %0t: second fill for page %h", $time, fillAddr);
                protoErrs++;
            end else begin
                fillSeen[r] = 1'b1;
                fillCount++;
                checkFault(fillFault, rows[r].expFault, "fill fault");
                checkWrOp(fillWrOp, rows[r].wrOp, "fill write flag");
                if (!rows[r].expFault) checkPhys(fillPhys, rows[r].expPhys, "fill page");
            end
        end
        // an ack needs a free entry
        if (missAck && !ackPrev) begin
            if (ackCount - fillCount >= devTlbCfgPkg::NumTrk) begin
                $display("Error at %0t: miss acknowledged with every entry busy", $time);
                protoErrs++;
            end
            ackCount++;
        end
        ackPrev = missAck;
    endtask

    initial begin
        ackPrev = 1'b0;
        ackCount = 0;
        fillCount = 0;
        for (int r = 0; r < NumRows; r++) fillSeen[r] = 1'b0;
        forever begin
            @(posedge clk);
            if (rstN) watchOutputs();
        end
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < CycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Error: run did not finish within %0d cycles", CycleLimit);
        $display("Verification failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        int r;
        valErrs = 0;
        protoErrs = 0;
        rstN = 1'b0;
        missReq = 1'b0;
        missAddr = '0;
        missWrOp = 1'b0;
        // idx page wr err np prsOk inv afterInv wait offset expPhys fault ats prs
        addRow(0, 20'h12345, 1'b1, 0, 0, 1'b1, 1'b0, 1'b0, 1'b1, 24'h100000, 24'h112345,
            1'b0, 1, 0);
        addRow(1, 20'h0ABCD, 1'b0, 2, 0, 1'b1, 1'b0, 1'b0, 1'b1, 24'h200000, 24'h20ABCD,
            1'b0, 3, 0);
        addRow(2, 20'h33000, 1'b1, 0, 1, 1'b1, 1'b0, 1'b0, 1'b1, 24'h050000, 24'h083000,
            1'b0, 2, 1);
        // budget runs out on the third not-present
        addRow(3, 20'h44440, 1'b0, 0, 3, 1'b1, 1'b0, 1'b0, 1'b1, 24'h000100, 24'h000000,
            1'b1, 3, 2);
        addRow(4, 20'h55501, 1'b1, 0, 1, 1'b0, 1'b0, 1'b0, 1'b1, 24'h000000, 24'h000000,
            1'b1, 1, 1);
        addRow(5, 20'h66600, 1'b0, 0, 0, 1'b1, 1'b1, 1'b0, 1'b0, 24'h001000, 24'h467600,
            1'b0, 2, 0);
        addRow(6, 20'h77007, 1'b1, 0, 0, 1'b1, 1'b0, 1'b1, 1'b1, 24'h002000, 24'h079007,
            1'b0, 1, 0);
        // three back to back, the third waits for a free entry
        addRow(7, 20'h88000, 1'b0, 0, 0, 1'b1, 1'b0, 1'b0, 1'b0, 24'h010000, 24'h098000,
            1'b0, 1, 0);
        addRow(8, 20'h99000, 1'b1, 1, 0, 1'b1, 1'b0, 1'b0, 1'b0, 24'h020000, 24'h0B9000,
            1'b0, 2, 0);
        addRow(9, 20'hAAA00, 1'b0, 0, 0, 1'b1, 1'b0, 1'b0, 1'b0, 24'h030000, 24'h0DAA00,
            1'b0, 1, 0);
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        for (r = 0; r < NumRows; r++) presentMiss(r);
        while (fillCount < NumRows) @(posedge clk);
        // room for a stray second fill
        repeat (50) @(posedge clk);
        for (r = 0; r < NumRows; r++) begin
            if (!fillSeen[r]) begin
                $display("Error: no fill arrived for page %h", rows[r].virt);
                protoErrs++;
            end
            checkCount(atsCount[r], rows[r].expAts,
                $sformatf("translation requests for %h", rows[r].virt));
            checkCount(prsCount[r], rows[r].expPrs,
                $sformatf("page requests for %h", rows[r].virt));
        end
        $display("errors: %0d wrong values, %0d protocol", valErrs, protoErrs);
        if (valErrs == 0 && protoErrs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* src/devTlbMissTop.sv */
// ----------------------------------------------------------------------
// miss tracker top, intake plus NumTrk entries plus output arbiter
// ----------------------------------------------------------------------

module devTlbMissTop (
    input  logic clk,
    input  logic rstN,
    input  logic missReq,
    input  devTlbTypesPkg::virtPage_t missAddr,
    input  logic missWrOp,
    output logic missAck,
    input  logic invStart,
    input  logic invEnd,
    output logic atsReq,
    input  logic atsAck,
    output devTlbTypesPkg::trkTag_t atsTag,
    output devTlbTypesPkg::virtPage_t atsAddr,
    input  logic atsRsp,
    input  devTlbTypesPkg::trkTag_t atsRspTag,
    input  devTlbTypesPkg::atsSts_t atsRspSts,
    input  devTlbTypesPkg::physPage_t atsRspPhys,
    output logic prsReq,
    input  logic prsAck,
    output devTlbTypesPkg::trkTag_t prsTag,
    output devTlbTypesPkg::virtPage_t prsAddr,
    input  logic prsRsp,
    input  devTlbTypesPkg::trkTag_t prsRspTag,
    input  devTlbTypesPkg::prsSts_t prsRspSts,
    output logic fillVld,
    output devTlbTypesPkg::virtPage_t fillAddr,
    output devTlbTypesPkg::physPage_t fillPhys,
    output logic fillFault,
    output logic fillWrOp
);

    // one link per entry
    missTrkIf trkBus [devTlbCfgPkg::NumTrk] ();

    missIntake missIntake_inst (.clk(clk), .rstN(rstN), .missReq(missReq), .missAddr(missAddr),
        .missWrOp(missWrOp), .missAck(missAck), .trk(trkBus));

    // entries see every response, filter by tag
    for (genvar g = 0; g < devTlbCfgPkg::NumTrk; g++) begin : genEntry
        missTrkEntry #(.trkIdx(g)) missTrkEntry_inst (.clk(clk), .rstN(rstN), .trk(trkBus[g]),
            .invStart(invStart), .invEnd(invEnd), .atsRsp(atsRsp), .atsRspTag(atsRspTag),
            .atsRspSts(atsRspSts), .atsRspPhys(atsRspPhys), .prsRsp(prsRsp),
            .prsRspTag(prsRspTag), .prsRspSts(prsRspSts));
    end

    missOutArb missOutArb_inst (.clk(clk), .rstN(rstN), .trk(trkBus), .atsReq(atsReq),
        .atsAck(atsAck), .atsTag(atsTag), .atsAddr(atsAddr), .prsReq(prsReq), .prsAck(prsAck),
        .prsTag(prsTag), .prsAddr(prsAddr), .fillVld(fillVld), .fillAddr(fillAddr),
        .fillPhys(fillPhys), .fillFault(fillFault), .fillWrOp(fillWrOp));

endmodule

/* src/missOutArb.sv */
// ----------------------------------------------------------------------
// round-robin grant of entry requests, one grant per cycle
// fill beats page request beats translation; fill has no back-pressure
// ----------------------------------------------------------------------

module missOutArb (
    input  logic clk,
    input  logic rstN,
    missTrkIf.arb trk [devTlbCfgPkg::NumTrk],
    output logic atsReq,
    input  logic atsAck,
    output devTlbTypesPkg::trkTag_t atsTag,
    output devTlbTypesPkg::virtPage_t atsAddr,
    output logic prsReq,
    input  logic prsAck,
    output devTlbTypesPkg::trkTag_t prsTag,
    output devTlbTypesPkg::virtPage_t prsAddr,
    output logic fillVld,
    output devTlbTypesPkg::virtPage_t fillAddr,
    output devTlbTypesPkg::physPage_t fillPhys,
    output logic fillFault,
    output logic fillWrOp
);

    localparam int N = devTlbCfgPkg::NumTrk;

    logic [N-1:0] atsEl, prsEl, fillEl, gntVec, wrOpVec, faultVec;
    devTlbTypesPkg::virtPage_t addrArr [N];
    devTlbTypesPkg::physPage_t physArr [N];
    devTlbTypesPkg::trkTag_t rrPtr, winner;
    logic atsBusy, prsBusy, atsSel, prsSel, fillSel;

    // first eligible at or after ptr
    function automatic devTlbTypesPkg::trkTag_t pickRr(input logic [N-1:0] el,
                                                       input devTlbTypesPkg::trkTag_t ptr);
        int idx;
        devTlbTypesPkg::trkTag_t res;
        res = ptr;
        for (int i = N - 1; i >= 0; i--) begin
            idx = (int'(ptr) + i) % N;
            if (el[idx]) res = devTlbTypesPkg::trkTag_t'(idx);
        end
        return res;
    endfunction

    for (genvar g = 0; g < N; g++) begin : genTrk
        // a busy channel holds back further requests of its kind
        assign atsEl[g] = trk[g].atsArbReq && !atsBusy;
        assign prsEl[g] = trk[g].prsArbReq && !prsBusy;
        assign fillEl[g] = trk[g].fillArbReq;
        assign addrArr[g] = trk[g].savedAddr;
        assign physArr[g] = trk[g].physResult;
        assign wrOpVec[g] = trk[g].savedWrOp;
        assign faultVec[g] = trk[g].faultResult;
        assign trk[g].gnt = gntVec[g];
    end

    always_comb begin
        fillSel = |fillEl;
        prsSel = !fillSel && (|prsEl);
        atsSel = !fillSel && !prsSel && (|atsEl);
        if (fillSel) winner = pickRr(fillEl, rrPtr);
        else if (prsSel) winner = pickRr(prsEl, rrPtr);
        else winner = pickRr(atsEl, rrPtr);
        gntVec = '0;
        if (fillSel || prsSel || atsSel) gntVec[winner] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            {rrPtr, atsReq, atsBusy, prsReq, prsBusy, fillVld} <= '0;
        end else begin
            fillVld <= fillSel;
            if (|gntVec) rrPtr <= (int'(winner) == N - 1) ? '0 : winner + 1'b1;
            // req until ack rises, busy until ack falls
            if (atsSel) {atsReq, atsBusy} <= 2'b11;
            else if (atsReq && atsAck) atsReq <= 1'b0;
            else if (atsBusy && !atsReq && !atsAck) atsBusy <= 1'b0;
            if (prsSel) {prsReq, prsBusy} <= 2'b11;
            else if (prsReq && prsAck) prsReq <= 1'b0;
            else if (prsBusy && !prsReq && !prsAck) prsBusy <= 1'b0;
        end
    end

    // channel and fill payload
    always_ff @(posedge clk) begin
        if (atsSel) {atsTag, atsAddr} <= {winner, addrArr[winner]};
        if (prsSel) {prsTag, prsAddr} <= {winner, addrArr[winner]};
        if (fillSel) begin
            {fillAddr, fillPhys} <= {addrArr[winner], physArr[winner]};
            {fillFault, fillWrOp} <= {faultVec[winner], wrOpVec[winner]};
        end
    end

endmodule

/* src/missTrkEntry.sv */
// ----------------------------------------------------------------------
// one miss tracker entry, acts only on responses tagged with trkIdx
// invStart/invEnd are single-cycle pulses framing a window
// ----------------------------------------------------------------------

module missTrkEntry #(
    parameter int trkIdx = 0
) (
    input  logic clk,
    input  logic rstN,
    missTrkIf.entry trk,
    input  logic invStart,
    input  logic invEnd,
    input  logic atsRsp,
    input  devTlbTypesPkg::trkTag_t atsRspTag,
    input  devTlbTypesPkg::atsSts_t atsRspSts,
    input  devTlbTypesPkg::physPage_t atsRspPhys,
    input  logic prsRsp,
    input  devTlbTypesPkg::trkTag_t prsRspTag,
    input  devTlbTypesPkg::prsSts_t prsRspSts
);

    devTlbTypesPkg::trkState_t state;
    devTlbTypesPkg::trkState_t nextState;
    devTlbTypesPkg::trkState_t reqOrHold;
    devTlbTypesPkg::trkTag_t ownTag;
    devTlbTypesPkg::prsCnt_t budget;
    logic invOpen;
    logic winOpen;
    logic atsHit;
    logic prsHit;
    // datapath strobes from the FSM
    logic savePhys;
    logic setFault;
    logic spendRound;

    assign ownTag = devTlbTypesPkg::trkTag_t'(trkIdx);
    assign atsHit = atsRsp && (atsRspTag == ownTag);
    assign prsHit = prsRsp && (prsRspTag == ownTag);

    // window is open from the invStart cycle until invEnd
    assign winOpen = (invOpen && !invEnd) || invStart;
    assign reqOrHold = winOpen ? devTlbTypesPkg::trkHold : devTlbTypesPkg::trkAtsArb;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            invOpen <= 1'b0;
        end else if (invStart) begin
            invOpen <= 1'b1;
        end else if (invEnd) begin
            invOpen <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------
    always_comb begin
        nextState = state;
        savePhys = 1'b0;
        setFault = 1'b0;
        spendRound = 1'b0;
        case (state)
            devTlbTypesPkg::trkIdle: begin
                if (trk.put) nextState = reqOrHold;
            end
            devTlbTypesPkg::trkHold: begin
                if (invEnd) nextState = devTlbTypesPkg::trkAtsArb;
            end
            devTlbTypesPkg::trkAtsArb: begin
                // granted as the window opens, its response is stale
                if (trk.gnt && invStart) nextState = devTlbTypesPkg::trkAtsStale;
                else if (trk.gnt) nextState = devTlbTypesPkg::trkAtsWait;
                else if (invStart) nextState = devTlbTypesPkg::trkHold;
            end
            devTlbTypesPkg::trkAtsWait: begin
                if (invStart) begin
                    // response in the invStart cycle is dropped as well
                    nextState = atsHit ? devTlbTypesPkg::trkHold : devTlbTypesPkg::trkAtsStale;
                end else if (atsHit) begin
                    case (atsRspSts)
                        devTlbTypesPkg::atsOk: begin
                            savePhys = 1'b1;
                            nextState = devTlbTypesPkg::trkFillArb;
                        end
                        devTlbTypesPkg::atsNotPresent: begin
                            if (budget != '0) begin
                                nextState = devTlbTypesPkg::trkPrsArb;
                            end else begin
                                setFault = 1'b1;
                                nextState = devTlbTypesPkg::trkFillArb;
                            end
                        end
                        // error, ask again
                        default: nextState = reqOrHold;
                    endcase
                end
            end
            devTlbTypesPkg::trkAtsStale: begin
                if (atsHit) nextState = reqOrHold;
            end
            devTlbTypesPkg::trkPrsArb: begin
                if (trk.gnt) nextState = devTlbTypesPkg::trkPrsWait;
            end
            devTlbTypesPkg::trkPrsWait: begin
                if (prsHit && (prsRspSts == devTlbTypesPkg::prsSuccess)) begin
                    spendRound = 1'b1;
                    nextState = reqOrHold;
                end else if (prsHit) begin
                    setFault = 1'b1;
                    nextState = devTlbTypesPkg::trkFillArb;
                end
            end
            devTlbTypesPkg::trkFillArb: begin
                if (trk.gnt) nextState = devTlbTypesPkg::trkIdle;
            end
            default: nextState = devTlbTypesPkg::trkIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= devTlbTypesPkg::trkIdle;
        end else begin
            state <= nextState;
        end
    end

    // ------------------------------------------------------------------
    // saved miss and result
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == devTlbTypesPkg::trkIdle && trk.put) begin
            trk.savedAddr <= trk.putAddr;
            trk.savedWrOp <= trk.putWrOp;
            budget <= devTlbTypesPkg::prsCnt_t'(devTlbCfgPkg::PrsRetryMax);
            trk.faultResult <= 1'b0;
        end else begin
            if (savePhys) trk.physResult <= atsRspPhys;
            if (setFault) trk.faultResult <= 1'b1;
            if (spendRound) budget <= budget - 1'b1;
        end
    end

    // request lines straight from state
    assign trk.vacant = (state == devTlbTypesPkg::trkIdle);
    assign trk.atsArbReq = (state == devTlbTypesPkg::trkAtsArb);
    assign trk.prsArbReq = (state == devTlbTypesPkg::trkPrsArb);
    assign trk.fillArbReq = (state == devTlbTypesPkg::trkFillArb);

endmodule

/* src/missIntake.sv */
// ----------------------------------------------------------------------
// four-phase miss intake, one miss in flight at a time
// missAck stays low while no entry is vacant
// ----------------------------------------------------------------------

module missIntake (
    input  logic clk,
    input  logic rstN,
    input  logic missReq,
    input  devTlbTypesPkg::virtPage_t missAddr,
    input  logic missWrOp,
    output logic missAck,
    missTrkIf.intake trk [devTlbCfgPkg::NumTrk]
);

    logic [devTlbCfgPkg::NumTrk-1:0] vacantVec;
    logic [devTlbCfgPkg::NumTrk-1:0] selOneHot;
    logic [devTlbCfgPkg::NumTrk-1:0] putVec;
    devTlbTypesPkg::virtPage_t putAddrR;
    logic putWrOpR;
    // set from put until ack drops
    logic inFlight;

    // gather vacancy, fan out the put
    for (genvar g = 0; g < devTlbCfgPkg::NumTrk; g++) begin : genTrk
        assign vacantVec[g] = trk[g].vacant;
        assign trk[g].put = putVec[g];
        assign trk[g].putAddr = putAddrR;
        assign trk[g].putWrOp = putWrOpR;
    end

    // lowest numbered vacant entry
    assign selOneHot = vacantVec & (~vacantVec + 1'b1);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            putVec <= '0;
            missAck <= 1'b0;
            inFlight <= 1'b0;
        end else begin
            // put is a single-cycle pulse
            putVec <= '0;
            if (!inFlight && missReq && (|vacantVec)) begin
                putVec <= selOneHot;
                inFlight <= 1'b1;
            end
            // ack the cycle after the put
            if (|putVec) begin
                missAck <= 1'b1;
            end
            // requester dropped req, close the handshake
            if (missAck && !missReq) begin
                missAck <= 1'b0;
                inFlight <= 1'b0;
            end
        end
    end

    // payload captured with the put
    always_ff @(posedge clk) begin
        if (!inFlight && missReq) begin
            putAddrR <= missAddr;
            putWrOpR <= missWrOp;
        end
    end

endmodule

/* src/missTrkIf.sv */
// ----------------------------------------------------------------------
// link between intake, one tracker entry and the output arbiter
// one instance per entry
// ----------------------------------------------------------------------

interface missTrkIf;

    // intake to entry
    logic put;
    devTlbTypesPkg::virtPage_t putAddr;
    logic putWrOp;
    logic vacant;

    // entry to arbiter
    logic atsArbReq;
    logic prsArbReq;
    logic fillArbReq;
    devTlbTypesPkg::virtPage_t savedAddr;
    logic savedWrOp;
    devTlbTypesPkg::physPage_t physResult;
    logic faultResult;
    logic gnt;

    modport intake (output put, putAddr, putWrOp, input vacant);
    modport entry (input put, putAddr, putWrOp, gnt, output vacant, atsArbReq, prsArbReq,
        fillArbReq, savedAddr, savedWrOp, physResult, faultResult);
    modport arb (input atsArbReq, prsArbReq, fillArbReq, savedAddr, savedWrOp,
        physResult, faultResult, output gnt);

endinterface

/* src/devTlbTypesPkg.sv */
// ----------------------------------------------------------------------
// shared vector types and encodings of the miss tracker
// prsCnt_t must hold devTlbCfgPkg::PrsRetryMax
// ----------------------------------------------------------------------

package devTlbTypesPkg;

    // page numbers
    typedef logic [devTlbCfgPkg::VirtW-1:0] virtPage_t;
    typedef logic [devTlbCfgPkg::PhysW-1:0] physPage_t;

    // entry index carried on requests and responses
    typedef logic [devTlbCfgPkg::TagW-1:0] trkTag_t;

    // remaining page request rounds
    typedef logic [1:0] prsCnt_t;

    // translation response result
    typedef enum logic [1:0] {
        atsOk = 2'd0,
        atsErr = 2'd1,
        atsNotPresent = 2'd2
    } atsSts_t;

    // page request result
    typedef enum logic {
        prsSuccess = 1'b0,
        prsFailure = 1'b1
    } prsSts_t;

    // per-entry state machine
    typedef enum logic [2:0] {
        trkIdle, trkHold, trkAtsArb, trkAtsWait,
        trkAtsStale, trkPrsArb, trkPrsWait, trkFillArb
    } trkState_t;

endpackage

/* src/devTlbCfgPkg.sv */
// ----------------------------------------------------------------------
// sizing and policy constants for the translation miss tracker
// TagW must be wide enough to index NumTrk entries
// ----------------------------------------------------------------------

package devTlbCfgPkg;

    // tracker sizing
    localparam int NumTrk = 2;
    localparam int TagW = 1;

    // page number widths
    localparam int VirtW = 20;
    localparam int PhysW = 24;

    // successful page request rounds per miss before a forced fault
    localparam int PrsRetryMax = 2;

endpackage
